/* Bender.yml */
package:
  name: udp_rx_core

sources:
  - rtl/udp_rx_pkg.sv
  - rtl/axis_if.sv
  - rtl/udp_rx_fsm.sv
  - rtl/udp_hdr_capture.sv
  - rtl/payload_realign.sv
  - rtl/udp_rx_status.sv
  - rtl/udp_rx_core.sv
  - target: test
    files:
      - verif/udp_rx_tb.sv

/* build.f */
rtl/udp_rx_pkg.sv
rtl/axis_if.sv
rtl/udp_rx_fsm.sv
rtl/udp_hdr_capture.sv
rtl/payload_realign.sv
rtl/udp_rx_status.sv
rtl/udp_rx_core.sv
verif/udp_rx_tb.sv

/* rtl/axis_if.sv */
// ----------------------------------------------------------
// Byte-keyed stream with valid/ready handshake
// ----------------------------------------------------------
`timescale 1ns/10ps

interface axis_if
    import udp_rx_pkg::*;
();

    logic [DATA_W-1:0] tdata;
    logic [KEEP_W-1:0] tkeep;
    logic              tvalid;
    logic              tready;
    logic              tlast;
    logic              tuser;

    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport snk (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

/* rtl/payload_realign.sv */
// ----------------------------------------------------------
// Payload realigner, moves payload byte 0 to lane 0
// One output register, one flush beat for an overflowing tail
// ----------------------------------------------------------
`timescale 1ns/10ps

module payload_realign
    import udp_rx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    axis_if.snk               pay_stream,

    output logic [DATA_W-1:0] m_axis_tdata,
    output logic [KEEP_W-1:0] m_axis_tkeep,
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output logic              m_axis_tlast,
    output logic              m_axis_tuser,

    output logic              first_valid,
    output logic [7:0]        first_byte
);

    localparam int REM_BYTES = KEEP_W - PAYLOAD_LANE;
    localparam int LOW_W     = PAYLOAD_LANE * 8;

    logic [REM_BYTES*8-1:0] rem_data;
    logic [REM_BYTES-1:0]   rem_keep;
    logic rem_valid;
    logic flush_pending;
    logic user_acc;
    logic first_out;
    logic can_load;
    logic in_fire;
    logic out_fire;
    logic need_flush;

    assign can_load          = !m_axis_tvalid || m_axis_tready;
    assign pay_stream.tready = can_load && !flush_pending;
    assign in_fire           = pay_stream.tvalid && pay_stream.tready;
    assign out_fire          = m_axis_tvalid && m_axis_tready;

    // Last raw beat still holds bytes above lane 1, so they need a beat of their own
    assign need_flush = pay_stream.tlast && rem_valid
                     && |pay_stream.tkeep[KEEP_W-1:PAYLOAD_LANE];

    always_ff @(posedge clk) begin
        if (rst) begin
            m_axis_tvalid <= 1'b0;
            rem_valid     <= 1'b0;
            flush_pending <= 1'b0;
            user_acc      <= 1'b0;
            first_out     <= 1'b1;
            first_valid   <= 1'b0;
        end else begin
            if (m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
            end
            if (flush_pending && can_load) begin
                m_axis_tvalid <= 1'b1;
                flush_pending <= 1'b0;
                rem_valid     <= 1'b0;
                user_acc      <= 1'b0;
            end else if (in_fire) begin
                // The first raw beat only fills the remainder, unless it ends the frame
                m_axis_tvalid <= rem_valid || pay_stream.tlast;
                rem_valid     <= !pay_stream.tlast || need_flush;
                flush_pending <= need_flush;
                if (pay_stream.tlast && !need_flush) begin
                    user_acc <= 1'b0;
                end else begin
                    user_acc <= user_acc || pay_stream.tuser;
                end
            end

            first_valid <= 1'b0;
            if (out_fire) begin
                first_valid <= first_out;
                first_out   <= m_axis_tlast;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_fire) begin
            first_byte <= m_axis_tdata[7:0];
        end
        if (flush_pending && can_load) begin
            m_axis_tdata <= {{LOW_W{1'b0}}, rem_data};
            m_axis_tkeep <= {{PAYLOAD_LANE{1'b0}}, rem_keep};
            m_axis_tlast <= 1'b1;
            m_axis_tuser <= user_acc;
        end else if (in_fire) begin
            // Remainder in the low lanes, two new bytes on top
            if (rem_valid) begin
                m_axis_tdata <= {pay_stream.tdata[LOW_W-1:0], rem_data};
                m_axis_tkeep <= {pay_stream.tkeep[PAYLOAD_LANE-1:0], rem_keep};
            end else begin
                m_axis_tdata <= {{LOW_W{1'b0}}, pay_stream.tdata[DATA_W-1:LOW_W]};
                m_axis_tkeep <= {{PAYLOAD_LANE{1'b0}},
                                 pay_stream.tkeep[KEEP_W-1:PAYLOAD_LANE]};
            end
            m_axis_tlast <= pay_stream.tlast && !need_flush;
            m_axis_tuser <= pay_stream.tlast && !need_flush
                         && (user_acc || pay_stream.tuser);
            rem_data     <= pay_stream.tdata[DATA_W-1:LOW_W];
            rem_keep     <= pay_stream.tkeep[KEEP_W-1:PAYLOAD_LANE];
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid
            && $stable(m_axis_tdata) && $stable(m_axis_tkeep) && $stable(m_axis_tlast)
    ) else $error("output beat changed while stalled");

endmodule

/* rtl/udp_hdr_capture.sv */
// ----------------------------------------------------------
// Header field capture and receive filter
// ----------------------------------------------------------
`timescale 1ns/10ps

module udp_hdr_capture
    import udp_rx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] tdata,
    input  logic              hdr_beat_valid,
    input  beat_idx_t         beat_idx,
    input  mac_t              local_mac,
    input  ip_addr_t          local_ip,
    input  udp_port_t         udp_port,
    output udp_hdr_t          hdr,
    output logic              hdr_match
);

    // Version 4, IHL 5
    localparam logic [7:0] IPV4_VER_IHL = 8'h45;

    logic [KEEP_W-1:0][7:0] b;
    logic type_ok;
    logic ver_ok;
    logic proto_ok;
    logic mac_ok;

    // Lane 0 carries the lowest byte offset
    assign b = tdata;

    always_ff @(posedge clk) begin
        if (hdr_beat_valid) begin
            case (beat_idx)
                3'd0: begin
                    hdr.dest_mac        <= {b[0], b[1], b[2], b[3], b[4], b[5]};
                    hdr.src_mac[47:32]  <= {b[6], b[7]};
                end
                3'd1: hdr.src_mac[31:0] <= {b[0], b[1], b[2], b[3]};
                3'd3: begin
                    hdr.src_ip          <= {b[2], b[3], b[4], b[5]};
                    hdr.dest_ip[31:16]  <= {b[6], b[7]};
                end
                3'd4: begin
                    hdr.dest_ip[15:0]   <= {b[0], b[1]};
                    hdr.src_port        <= {b[2], b[3]};
                    hdr.dest_port       <= {b[4], b[5]};
                    hdr.udp_length      <= {b[6], b[7]};
                end
                default: ;
            endcase
        end
    end

    // EtherType and version/IHL sit in beat 1, protocol in lane 7 of beat 2
    always_ff @(posedge clk) begin
        if (rst) begin
            type_ok  <= 1'b0;
            ver_ok   <= 1'b0;
            proto_ok <= 1'b0;
        end else if (hdr_beat_valid) begin
            if (beat_idx == 3'd1) begin
                type_ok <= ({b[4], b[5]} == ETHERTYPE_IPV4);
                ver_ok  <= (b[6] == IPV4_VER_IHL);
            end
            if (beat_idx == 3'd2) begin
                proto_ok <= (b[7] == IP_PROTO_UDP);
            end
        end
    end

    assign mac_ok = (hdr.dest_mac == local_mac) || (hdr.dest_mac == MAC_BROADCAST);

    assign hdr_match = mac_ok && type_ok && ver_ok && proto_ok
                    && (hdr.dest_ip == local_ip)
                    && (hdr.dest_port == udp_port);

endmodule

/* rtl/udp_rx_core.sv */
// ----------------------------------------------------------
// UDP receive core top level for a 64-bit 10G port
// Filters frames and outputs the realigned UDP payload
// ----------------------------------------------------------
`timescale 1ns/10ps

module udp_rx_core
    import udp_rx_pkg::*;
#(
    parameter int STAT_W = 16
) (
    input  logic              clk,
    input  logic              rst,

    input  logic [DATA_W-1:0] s_axis_tdata,
    input  logic [KEEP_W-1:0] s_axis_tkeep,
    input  logic              s_axis_tvalid,
    output logic              s_axis_tready,
    input  logic              s_axis_tlast,
    input  logic              s_axis_tuser,

    output logic [DATA_W-1:0] m_axis_tdata,
    output logic [KEEP_W-1:0] m_axis_tkeep,
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output logic              m_axis_tlast,
    output logic              m_axis_tuser,

    input  mac_t              local_mac,
    input  ip_addr_t          local_ip,
    input  udp_port_t         udp_port,

    output logic [7:0]        led,
    output logic [STAT_W-1:0] frames_ok,
    output logic [STAT_W-1:0] frames_dropped
);

    axis_if pay_stream ();

    logic      hdr_match;
    logic      hdr_beat_valid;
    beat_idx_t beat_idx;
    logic      frame_ok;
    logic      frame_drop;
    logic      first_valid;
    logic [7:0] first_byte;

    udp_rx_fsm fsm0 (
        .clk            (clk),
        .rst            (rst),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tkeep   (s_axis_tkeep),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tready  (s_axis_tready),
        .s_axis_tlast   (s_axis_tlast),
        .s_axis_tuser   (s_axis_tuser),
        .hdr_match      (hdr_match),
        .hdr_beat_valid (hdr_beat_valid),
        .beat_idx       (beat_idx),
        .pay_stream     (pay_stream),
        .frame_ok       (frame_ok),
        .frame_drop     (frame_drop)
    );

    // Header record is kept inside the capture block
    udp_hdr_capture hdr0 (
        .clk            (clk),
        .rst            (rst),
        .tdata          (s_axis_tdata),
        .hdr_beat_valid (hdr_beat_valid),
        .beat_idx       (beat_idx),
        .local_mac      (local_mac),
        .local_ip       (local_ip),
        .udp_port       (udp_port),
        .hdr            (),
        .hdr_match      (hdr_match)
    );

    payload_realign realign0 (
        .clk            (clk),
        .rst            (rst),
        .pay_stream     (pay_stream),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tkeep   (m_axis_tkeep),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tready  (m_axis_tready),
        .m_axis_tlast   (m_axis_tlast),
        .m_axis_tuser   (m_axis_tuser),
        .first_valid    (first_valid),
        .first_byte     (first_byte)
    );

    udp_rx_status #(
        .STAT_W (STAT_W)
    ) status0 (
        .clk            (clk),
        .rst            (rst),
        .frame_ok       (frame_ok),
        .frame_drop     (frame_drop),
        .first_valid    (first_valid),
        .first_byte     (first_byte),
        .frames_ok      (frames_ok),
        .frames_dropped (frames_dropped),
        .led            (led)
    );

endmodule

/* rtl/udp_rx_fsm.sv */
// ----------------------------------------------------------
// Frame FSM for the UDP receive path
// Walks header beats, then forwards or drops the rest
// ----------------------------------------------------------
`timescale 1ns/10ps

module udp_rx_fsm
    import udp_rx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [DATA_W-1:0] s_axis_tdata,
    input  logic [KEEP_W-1:0] s_axis_tkeep,
    input  logic              s_axis_tvalid,
    output logic              s_axis_tready,
    input  logic              s_axis_tlast,
    input  logic              s_axis_tuser,

    input  logic              hdr_match,
    output logic              hdr_beat_valid,
    output beat_idx_t         beat_idx,

    axis_if.src               pay_stream,

    output logic              frame_ok,
    output logic              frame_drop
);

    // Beat 4 is the last header-only beat
    localparam beat_idx_t LAST_HDR_BEAT = beat_idx_t'(HDR_BEATS - 2);

    parse_state_e state;
    beat_idx_t    beat_cnt;
    logic         keep_frame;
    logic         s_fire;

    // hdr_match is settled once beat 4 is in, and stays put until the next frame
    assign keep_frame    = (state == ST_PAYLOAD) && hdr_match;
    assign s_axis_tready = keep_frame ? pay_stream.tready : 1'b1;
    assign s_fire        = s_axis_tvalid && s_axis_tready;

    assign hdr_beat_valid = s_fire && (state == ST_HDR);
    assign beat_idx       = beat_cnt;

    // Raw beats from beat 5 onward
    assign pay_stream.tdata  = s_axis_tdata;
    assign pay_stream.tkeep  = s_axis_tkeep;
    assign pay_stream.tlast  = s_axis_tlast;
    assign pay_stream.tuser  = s_axis_tuser;
    assign pay_stream.tvalid = s_axis_tvalid && keep_frame;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_HDR;
            beat_cnt   <= '0;
            frame_ok   <= 1'b0;
            frame_drop <= 1'b0;
        end else begin
            frame_ok   <= 1'b0;
            frame_drop <= 1'b0;
            if (s_fire) begin
                case (state)
                    ST_HDR: begin
                        if (s_axis_tlast) begin
                            // Frame ended inside the header
                            frame_drop <= 1'b1;
                            beat_cnt   <= '0;
                        end else if (beat_cnt == LAST_HDR_BEAT) begin
                            state    <= ST_PAYLOAD;
                            beat_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                    ST_PAYLOAD: begin
                        // Keep or drop decided on beat 5
                        if (s_axis_tlast) begin
                            state      <= ST_HDR;
                            frame_ok   <= hdr_match;
                            frame_drop <= !hdr_match;
                        end else if (!hdr_match) begin
                            state <= ST_DROP;
                        end
                    end
                    default: begin
                        if (s_axis_tlast) begin
                            state      <= ST_HDR;
                            frame_drop <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // A forwarded last beat closes the frame as accepted
    a_pay_last_closes: assert property (
        @(posedge clk) disable iff (rst)
        pay_stream.tvalid && pay_stream.tready && pay_stream.tlast
            |=> (state == ST_HDR) && frame_ok
    ) else $error("forwarded last beat did not close the frame");

endmodule

/* rtl/udp_rx_pkg.sv */
// ----------------------------------------------------------
// UDP receive core shared definitions
// Stream widths, protocol constants, header record and states
// ----------------------------------------------------------
package udp_rx_pkg;

    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // Header bytes 0..41 span beats 0..5, payload starts at lane 2 of beat 5
    localparam int HDR_BEATS    = 6;
    localparam int PAYLOAD_LANE = 2;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [2:0]  beat_idx_t;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam mac_t        MAC_BROADCAST  = 48'hffff_ffff_ffff;

    typedef struct packed {
        mac_t      dest_mac;
        mac_t      src_mac;
        ip_addr_t  src_ip;
        ip_addr_t  dest_ip;
        udp_port_t src_port;
        udp_port_t dest_port;
        logic [15:0] udp_length;
    } udp_hdr_t;

    typedef enum logic [1:0] {
        ST_HDR,
        ST_PAYLOAD,
        ST_DROP
    } parse_state_e;

endpackage

/* rtl/udp_rx_status.sv */
// ----------------------------------------------------------
// Frame counters and LED latch
// ----------------------------------------------------------
`timescale 1ns/10ps

module udp_rx_status #(
    parameter int STAT_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_ok,
    input  logic              frame_drop,
    input  logic              first_valid,
    input  logic [7:0]        first_byte,
    output logic [STAT_W-1:0] frames_ok,
    output logic [STAT_W-1:0] frames_dropped,
    output logic [7:0]        led
);

    always_ff @(posedge clk) begin
        if (rst) begin
            frames_ok      <= '0;
            frames_dropped <= '0;
            led            <= '0;
        end else begin
            // Both counters stop at all ones
            if (frame_ok && !(&frames_ok)) begin
                frames_ok <= frames_ok + 1'b1;
            end
            if (frame_drop && !(&frames_dropped)) begin
                frames_dropped <= frames_dropped + 1'b1;
            end
            if (first_valid) begin
                led <= first_byte;
            end
        end
    end

    a_one_verdict: assert property (
        @(posedge clk) disable iff (rst) !(frame_ok && frame_drop)
    ) else $error("frame both accepted and dropped");

endmodule

/* verif/udp_rx_tb.sv */
// ----------------------------------------------------------
// Testbench for the UDP receive core
// Table of frames, payload scoreboard and status checks
// ----------------------------------------------------------
`timescale 1ns/10ps

module udp_rx_tb
    import udp_rx_pkg::*;
();

    localparam int          STAT_W    = 16;
    localparam int          TIMEOUT   = 300;
    localparam int unsigned SEED      = 32'h9f27_f010;
    localparam mac_t        LOCAL_MAC = 48'h02_00_00_aa_bb_cc;
    localparam ip_addr_t    LOCAL_IP  = 32'hc0a8_010a;
    localparam udp_port_t   UDP_PORT  = 16'd5000;

    typedef enum {K_GOOD, K_BAD_PORT, K_BAD_IP, K_BAD_TYPE, K_BCAST, K_SHORT} frame_kind_e;

    typedef struct {
        frame_kind_e kind;
        int          len;
        bit          bp;
        bit          accept;
        bit          err;
    } case_t;

    logic              clk;
    logic              rst;
    logic [DATA_W-1:0] s_axis_tdata;
    logic [KEEP_W-1:0] s_axis_tkeep;
    logic              s_axis_tvalid;
    logic              s_axis_tready;
    logic              s_axis_tlast;
    logic              s_axis_tuser;
    logic [DATA_W-1:0] m_axis_tdata;
    logic [KEEP_W-1:0] m_axis_tkeep;
    logic              m_axis_tvalid;
    logic              m_axis_tready;
    logic              m_axis_tlast;
    logic              m_axis_tuser;
    logic [7:0]        led;
    logic [STAT_W-1:0] frames_ok;
    logic [STAT_W-1:0] frames_dropped;

    case_t             cases[$];
    logic [7:0]        frame_bytes[$];
    logic [7:0]        payload[$];
    logic [DATA_W-1:0] exp_data_q[$];
    logic [KEEP_W-1:0] exp_keep_q[$];
    logic              exp_last_q[$];
    logic              exp_user_q[$];
    logic [DATA_W-1:0] act_data_q[$];
    logic [KEEP_W-1:0] act_keep_q[$];
    logic              act_last_q[$];
    logic              act_user_q[$];

    logic [STAT_W-1:0] exp_ok   = '0;
    logic [STAT_W-1:0] exp_drop = '0;
    logic [7:0]        exp_led  = '0;
    logic [255:0]      stall_pattern;
    logic [7:0]        stall_idx = '0;
    logic              bp_on     = 1'b0;
    int                mismatch_cnt = 0;
    int                fail_cnt     = 0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    udp_rx_core #(
        .STAT_W (STAT_W)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tkeep   (s_axis_tkeep),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tready  (s_axis_tready),
        .s_axis_tlast   (s_axis_tlast),
        .s_axis_tuser   (s_axis_tuser),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tkeep   (m_axis_tkeep),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tready  (m_axis_tready),
        .m_axis_tlast   (m_axis_tlast),
        .m_axis_tuser   (m_axis_tuser),
        .local_mac      (LOCAL_MAC),
        .local_ip       (LOCAL_IP),
        .udp_port       (UDP_PORT),
        .led            (led),
        .frames_ok      (frames_ok),
        .frames_dropped (frames_dropped)
    );

    // Output monitor, one entry per transferred beat
    always @(posedge clk) begin
        if (!rst && m_axis_tvalid && m_axis_tready) begin
            act_data_q.push_back(m_axis_tdata);
            act_keep_q.push_back(m_axis_tkeep);
            act_last_q.push_back(m_axis_tlast);
            act_user_q.push_back(m_axis_tuser);
        end
    end

    // Sink back-pressure from a pattern drawn at the start of the run
    always @(negedge clk) begin
        if (bp_on) begin
            m_axis_tready = stall_pattern[stall_idx];
            stall_idx     = stall_idx + 1'b1;
        end else begin
            m_axis_tready = 1'b1;
        end
    end

    task automatic compare_beat(input logic [DATA_W-1:0] got_data, want_data,
                                input logic [KEEP_W-1:0] got_keep, want_keep,
                                input logic got_last, want_last,
                                input logic got_user, want_user);
        logic [DATA_W-1:0] mask;
        for (int l = 0; l < KEEP_W; l++) begin
            mask[l*8 +: 8] = {8{want_keep[l]}};
        end
        if ((got_data & mask) !== (want_data & mask)) begin
            $display("MISMATCH t=%0t m_axis_tdata got %h exp %h", $time, got_data, want_data);
            mismatch_cnt++;
        end
        if (got_keep !== want_keep) begin
            $display("MISMATCH t=%0t m_axis_tkeep got %h exp %h", $time, got_keep, want_keep);
            mismatch_cnt++;
        end
        if (got_last !== want_last) begin
            $display("MISMATCH t=%0t m_axis_tlast got %b exp %b", $time, got_last, want_last);
            mismatch_cnt++;
        end
        if (got_user !== want_user) begin
            $display("MISMATCH t=%0t m_axis_tuser got %b exp %b", $time, got_user, want_user);
            mismatch_cnt++;
        end
    endtask

    task automatic compare_count(input string name, input logic [STAT_W-1:0] got,
                                 input logic [STAT_W-1:0] want);
        if (got !== want) begin
            $display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, want);
            mismatch_cnt++;
        end
    endtask

    task automatic compare_led(input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("MISMATCH t=%0t led got %h exp %h", $time, got, want);
            mismatch_cnt++;
        end
    endtask

    // Network byte order, most significant byte first
    task automatic push_field(input logic [47:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            frame_bytes.push_back(value[i*8 +: 8]);
        end
    endtask

    task automatic pack_word(ref logic [7:0] src[$], input int w,
                             output logic [DATA_W-1:0] data, output logic [KEEP_W-1:0] keep);
        data = '0;
        keep = '0;
        for (int l = 0; l < KEEP_W; l++) begin
            if (w * KEEP_W + l < src.size()) begin
                data[l*8 +: 8] = src[w * KEEP_W + l];
                keep[l]        = 1'b1;
            end
        end
    endtask

    task automatic build_frame(input frame_kind_e kind, input int len);
        mac_t        dst_mac;
        ip_addr_t    dst_ip;
        udp_port_t   dst_port;
        logic [15:0] etype;
        dst_mac  = (kind == K_BCAST)    ? MAC_BROADCAST       : LOCAL_MAC;
        dst_ip   = (kind == K_BAD_IP)   ? LOCAL_IP ^ 32'h1    : LOCAL_IP;
        dst_port = (kind == K_BAD_PORT) ? UDP_PORT + 16'd1    : UDP_PORT;
        etype    = (kind == K_BAD_TYPE) ? 16'h86dd            : ETHERTYPE_IPV4;
        frame_bytes.delete();
        payload.delete();
        push_field(dst_mac, 6);
        push_field(48'h02_11_22_33_44_55, 6);
        push_field(etype, 2);
        push_field(16'h4500, 2);
        push_field(16'(28 + len), 2);
        push_field(32'h0000_4000, 4);
        // TTL, then protocol
        push_field({8'd64, IP_PROTO_UDP}, 2);
        push_field(16'h0000, 2);
        push_field(32'hc0a8_0101, 4);
        push_field(dst_ip, 4);
        push_field(16'd1234, 2);
        push_field(dst_port, 2);
        push_field(16'(8 + len), 2);
        push_field(16'h0000, 2);
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
            frame_bytes.push_back(payload[i]);
        end
        // Ends inside the IP header
        if (kind == K_SHORT) begin
            while (frame_bytes.size() > 30) begin
                void'(frame_bytes.pop_back());
            end
            payload.delete();
        end
    endtask

    // An errored frame shows tuser on its last output beat only
    task automatic push_expected(input bit err);
        int                nwords;
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        nwords = (payload.size() + KEEP_W - 1) / KEEP_W;
        for (int w = 0; w < nwords; w++) begin
            pack_word(payload, w, data, keep);
            exp_data_q.push_back(data);
            exp_keep_q.push_back(keep);
            exp_last_q.push_back(w == nwords - 1);
            exp_user_q.push_back(err && (w == nwords - 1));
        end
    endtask

    task automatic send_frame(input bit err);
        int                nbeats;
        int                waited;
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        nbeats = (frame_bytes.size() + KEEP_W - 1) / KEEP_W;
        for (int b = 0; b < nbeats; b++) begin
            pack_word(frame_bytes, b, data, keep);
            @(negedge clk);
            s_axis_tdata  = data;
            s_axis_tkeep  = keep;
            s_axis_tvalid = 1'b1;
            s_axis_tlast  = (b == nbeats - 1);
            s_axis_tuser  = err && (b == nbeats - 1);
            waited = 0;
            @(posedge clk);
            while (!s_axis_tready && waited < TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (!s_axis_tready) begin
                $display("t=%0t input beat %0d was never accepted", $time, b);
                fail_cnt++;
            end
        end
        @(negedge clk);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = 1'b0;
    endtask

    task automatic wait_out_beats(input int n);
        int waited;
        waited = 0;
        while (act_data_q.size() < n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (act_data_q.size() < n) begin
            $display("t=%0t timed out waiting for %0d output beats, got %0d",
                     $time, n, act_data_q.size());
            fail_cnt++;
        end
    endtask

    task automatic wait_counts();
        int waited;
        waited = 0;
        while ((frames_ok !== exp_ok || frames_dropped !== exp_drop) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic wait_led();
        int waited;
        waited = 0;
        while (led !== exp_led && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic check_output();
        while (exp_data_q.size() != 0 && act_data_q.size() != 0) begin
            compare_beat(act_data_q.pop_front(), exp_data_q.pop_front(),
                         act_keep_q.pop_front(), exp_keep_q.pop_front(),
                         act_last_q.pop_front(), exp_last_q.pop_front(),
                         act_user_q.pop_front(), exp_user_q.pop_front());
        end
        exp_data_q.delete();
        exp_keep_q.delete();
        exp_last_q.delete();
        exp_user_q.delete();
    endtask

    task automatic run_case(input case_t c);
        int n_exp;
        @(posedge clk);
        bp_on = c.bp;
        build_frame(c.kind, c.len);
        if (c.accept) begin
            push_expected(c.err);
            exp_ok  = exp_ok + 1'b1;
            exp_led = payload[0];
        end else begin
            exp_drop = exp_drop + 1'b1;
        end
        n_exp = exp_data_q.size();
        send_frame(c.err);
        wait_out_beats(n_exp);
        check_output();
        wait_counts();
        compare_count("frames_ok", frames_ok, exp_ok);
        compare_count("frames_dropped", frames_dropped, exp_drop);
        if (act_data_q.size() != 0) begin
            $display("t=%0t %0d output beats appeared that no kept frame accounts for",
                     $time, act_data_q.size());
            fail_cnt++;
            act_data_q.delete();
            act_keep_q.delete();
            act_last_q.delete();
            act_user_q.delete();
        end
        wait_led();
        compare_led(led, exp_led);
    endtask

    // Last column flags an errored frame through tuser on its last beat
    task automatic load_cases();
        cases.push_back('{K_GOOD,      6, 1'b0, 1'b1, 1'b0});
        cases.push_back('{K_GOOD,      8, 1'b0, 1'b1, 1'b1});
        cases.push_back('{K_GOOD,     14, 1'b0, 1'b1, 1'b0});
        cases.push_back('{K_GOOD,     21, 1'b0, 1'b1, 1'b0});
        cases.push_back('{K_BAD_PORT, 14, 1'b0, 1'b0, 1'b0});
        cases.push_back('{K_BAD_IP,    8, 1'b0, 1'b0, 1'b0});
        cases.push_back('{K_BAD_TYPE, 21, 1'b0, 1'b0, 1'b1});
        cases.push_back('{K_SHORT,     0, 1'b0, 1'b0, 1'b0});
        cases.push_back('{K_BCAST,    21, 1'b0, 1'b1, 1'b0});
        cases.push_back('{K_GOOD,     21, 1'b1, 1'b1, 1'b1});
        cases.push_back('{K_GOOD,     14, 1'b1, 1'b1, 1'b0});
        cases.push_back('{K_BAD_PORT,  6, 1'b1, 1'b0, 1'b0});
        cases.push_back('{K_GOOD,     40, 1'b1, 1'b1, 1'b0});
        cases.push_back('{K_BCAST,     8, 1'b1, 1'b1, 1'b0});
    endtask

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = 1'b0;
        m_axis_tready = 1'b1;
        // Roughly one stall cycle in three
        for (int i = 0; i < 256; i++) begin
            stall_pattern[i] = ($urandom % 3) != 0;
        end
        load_cases();

        repeat (5) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        if (m_axis_tvalid !== 1'b0) begin
            $display("MISMATCH t=%0t m_axis_tvalid got %b exp 0", $time, m_axis_tvalid);
            mismatch_cnt++;
        end
        compare_count("frames_ok", frames_ok, '0);
        compare_count("frames_dropped", frames_dropped, '0);
        compare_led(led, 8'h00);

        foreach (cases[i]) begin
            run_case(cases[i]);
        end

        $display("Run complete: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
